// File: uart_app.f
design/uart_app_pkg.sv
design/frame_if.sv
design/uart_phy.sv
design/frame_parser.sv
design/cmd_decoder.sv
design/status_reporter.sv
design/uart_app.sv
dv/clk_gen.sv
dv/tb_uart_app.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_uart_app -f uart_app.f
	@out="$$(./obj_dir/Vtb_uart_app)"; echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf obj_dir

// File: dv/tb_uart_app.sv
// uart endpoint testbench
`timescale 1ns/1ps

module tb_uart_app;

	localparam int bit_clks = 8;	// 8N1 bit time
	localparam int report_bytes = 23;	// header 4, payload 18, tail 1
	// about 67 host bytes and 23 report bytes at ~82 clocks each,
	// plus settling, come to roughly 7500 cycles
	localparam int timeout_cycles = 20000;

	logic        clk_sys;
	logic        reset;
	logic        a7_led;
	logic        com_232_rx;
	logic [31:0] fpga_version_optic;
	logic [31:0] fpga_time_optic;
	logic [13:0] sfp_abs;
	logic [13:0] sfp_los;
	logic [13:0] rx_comm_err;
	logic [13:0] rx_verify_err;
	logic [10:0] serdes_state;
	logic        fpga_led;
	logic        com_232_tx;
	logic        soft_reset_cmd;
	logic        spi_flash_switch;
	logic [13:0] energy_fetch;
	logic [13:0] bridge_mode_set;

	logic [31:0] lcg_state = 32'd79;
	int          error_count = 0;
	int          test_errors = 0;
	int          test_count = 0;
	int          soft_pulses = 0;
	int          cycle_count = 0;

	clk_gen i_clk_gen (.clk_sys(clk_sys), .reset(reset));

	uart_app i_dut (.*);

	// one-cycle pulses, seen once at the falling edge
	always @(negedge clk_sys)
	begin
		if (!reset && soft_reset_cmd)
			soft_pulses++;
	end

	// ------------------------------------------------------------
	// helpers
	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic compare_value(input string test_name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
		begin
			$display("error %s: expected %0h, actual %0h", test_name, expected, actual);
			error_count++;
			test_errors++;
		end
	endtask

	task automatic note_failure(input string what);
		$display("%s", what);
		error_count++;
		test_errors++;
	endtask

	task automatic finish_test(input string test_name);
		test_count++;
		if (test_errors == 0)
			$display("test %s ok", test_name);
		else
			$display("test %s FAILED with %0d errors", test_name, test_errors);
		test_errors = 0;
	endtask

	task automatic send_byte(input logic [7:0] b);
		logic [9:0] bits;
		bits = {1'b1, b, 1'b0};	// stop, data lsb first, start
		for (int i = 0; i < 10; i++)
		begin
			@(negedge clk_sys);
			com_232_rx = bits[i];
			repeat (bit_clks - 1)
				@(negedge clk_sys);
		end
	endtask

	task automatic send_frame(input logic [7:0] cmd, input logic [7:0] len,
		input logic [7:0] p1, input logic [7:0] p2, input logic [7:0] tail);
		send_byte(8'hBE);
		send_byte(cmd);
		send_byte(8'h00);
		send_byte(len);
		send_byte(8'h00);
		if (len > 8'd0)
			send_byte(p1);
		if (len > 8'd1)
			send_byte(p2);
		send_byte(tail);
		// stop bit sample, parser and decoder add a few cycles
		repeat (2 * bit_clks)
			@(negedge clk_sys);
	endtask

	task automatic receive_byte(output logic [7:0] b);
		@(negedge com_232_tx);
		repeat (bit_clks / 2)
			@(negedge clk_sys);	// middle of the start bit
		if (com_232_tx !== 1'b0)
			note_failure("report byte start bit did not stay low");
		for (int i = 0; i < 8; i++)
		begin
			repeat (bit_clks)
				@(negedge clk_sys);
			b[i] = com_232_tx;
		end
		repeat (bit_clks)
			@(negedge clk_sys);
		if (com_232_tx !== 1'b1)
			note_failure("report byte stop bit was not high");
	endtask

	// ------------------------------------------------------------
	// tests
	task automatic test_status_report();
		logic [31:0] r;
		logic [8*report_bytes-1:0] expected;
		logic [7:0] got;
		@(negedge clk_sys);
		fpga_version_optic = lcg_next();
		fpga_time_optic = lcg_next();
		r = lcg_next();
		sfp_abs = r[13:0];
		r = lcg_next();
		sfp_los = r[13:0];
		r = lcg_next();
		rx_comm_err = r[13:0];
		r = lcg_next();
		rx_verify_err = r[13:0];
		r = lcg_next();
		serdes_state = r[10:0];
		a7_led = 1'b1;
		repeat (6)
			@(negedge clk_sys);	// through the led synchronizer
		compare_value("status_report", 32'd1, 32'(fpga_led));
		expected = {8'hBE, 8'h03, 8'h00, 8'h12, fpga_version_optic, fpga_time_optic,
			2'b00, sfp_abs, 2'b00, sfp_los, 2'b00, rx_comm_err, 2'b00, rx_verify_err,
			5'b00000, serdes_state, 8'hED};
		a7_led = 1'b0;	// falling edge starts the report
		for (int i = 0; i < report_bytes; i++)
		begin
			receive_byte(got);
			compare_value("status_report", 32'(expected[8*(report_bytes-1-i) +: 8]),
				32'(got));
		end
		compare_value("status_report", 32'd0, 32'(fpga_led));
		finish_test("status_report");
	endtask

	task automatic test_bridge_mode();
		send_frame(8'h30, 8'd2, 8'h2A, 8'h5C, 8'hED);
		compare_value("bridge_mode", 32'h2A5C, 32'(bridge_mode_set));
		finish_test("bridge_mode");
	endtask

	task automatic test_energy_mask();
		compare_value("energy_mask", 32'h3FFF, 32'(energy_fetch));
		send_frame(8'h25, 8'd2, 8'h15, 8'h81, 8'hED);
		compare_value("energy_mask", 32'h1581, 32'(energy_fetch));
		send_frame(8'h04, 8'd1, 8'h01, 8'h00, 8'hED);	// fault reset
		compare_value("energy_mask", 32'h0000, 32'(energy_fetch));
		send_frame(8'h04, 8'd1, 8'h00, 8'h00, 8'hED);	// soft reset
		compare_value("energy_mask", 32'h3FFF, 32'(energy_fetch));
		finish_test("energy_mask");
	endtask

	task automatic test_flash_switch();
		int pulses_before;
		pulses_before = soft_pulses;
		compare_value("flash_switch", 32'd0, 32'(spi_flash_switch));
		send_frame(8'h00, 8'd0, 8'h00, 8'h00, 8'hED);
		compare_value("flash_switch", 32'd1, 32'(spi_flash_switch));
		send_frame(8'h04, 8'd1, 8'h00, 8'h00, 8'hED);
		compare_value("flash_switch", 32'd0, 32'(spi_flash_switch));
		compare_value("flash_switch", 32'd1, 32'(soft_pulses - pulses_before));
		finish_test("flash_switch");
	endtask

	task automatic test_bad_framing();
		logic [13:0] bridge_before;
		logic [13:0] energy_before;
		int pulses_before;
		// noise ahead of the header
		send_byte(8'h55);
		send_byte(8'hED);
		send_frame(8'h30, 8'd2, 8'h01, 8'h02, 8'hED);
		compare_value("bad_framing", 32'h0102, 32'(bridge_mode_set));
		bridge_before = bridge_mode_set;
		energy_before = energy_fetch;
		pulses_before = soft_pulses;
		// payload differs from both masks and looks like a soft reset code
		send_frame(8'h7F, 8'd2, 8'h00, 8'h81, 8'hED);	// unknown command
		compare_value("bad_framing", 32'(bridge_before), 32'(bridge_mode_set));
		compare_value("bad_framing", 32'(energy_before), 32'(energy_fetch));
		compare_value("bad_framing", 32'd0, 32'(spi_flash_switch));
		compare_value("bad_framing", 32'(pulses_before), 32'(soft_pulses));
		send_frame(8'h00, 8'd0, 8'h00, 8'h00, 8'h00);	// wrong tail
		compare_value("bad_framing", 32'd0, 32'(spi_flash_switch));
		finish_test("bad_framing");
	endtask

	// ------------------------------------------------------------
	// main sequence
	initial
	begin
		a7_led = 1'b0;
		com_232_rx = 1'b1;	// line idles high
		fpga_version_optic = '0;
		fpga_time_optic = '0;
		sfp_abs = '0;
		sfp_los = '0;
		rx_comm_err = '0;
		rx_verify_err = '0;
		serdes_state = '0;
		@(negedge clk_sys);
		while (reset)
			@(negedge clk_sys);
		test_status_report();
		test_bridge_mode();
		test_energy_mask();
		test_flash_switch();
		test_bad_framing();
		$display("%0d tests run, %0d errors", test_count, error_count);
		if (error_count == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

	initial
	begin
		while (cycle_count < timeout_cycles)
		begin
			@(posedge clk_sys);
			cycle_count++;
		end
		$display("timeout: the DUT did not respond within %0d cycles", timeout_cycles);
		$display("Simulation failed");
		$finish;
	end

endmodule

// File: dv/clk_gen.sv
// testbench clock and reset
`timescale 1ns/1ps

module clk_gen
(
	output logic clk_sys,
	output logic reset
);

	initial
	begin
		clk_sys = 1'b0;
		forever
			#4 clk_sys = ~clk_sys;	// 8 ns period
	end

	// held over three rising edges
	initial
	begin
		reset = 1'b1;
		repeat (3)
			@(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;
	end

endmodule

// File: design/uart_app.sv
// board management uart endpoint
`timescale 1ns/1ps

module uart_app
	import uart_app_pkg::*;
(
	input  logic              clk_sys,
	input  logic              reset,
	input  logic              a7_led,
	input  logic              com_232_rx,
	input  logic [31:0]       fpga_version_optic,
	input  logic [31:0]       fpga_time_optic,
	input  logic [ch_num-1:0] sfp_abs,
	input  logic [ch_num-1:0] sfp_los,
	input  logic [ch_num-1:0] rx_comm_err,
	input  logic [ch_num-1:0] rx_verify_err,
	input  logic [10:0]       serdes_state,
	output logic              fpga_led,
	output logic              com_232_tx,
	output logic              soft_reset_cmd,
	output logic              spi_flash_switch,
	output logic [ch_num-1:0] energy_fetch,
	output logic [ch_num-1:0] bridge_mode_set
);

	logic       rx_valid;
	logic [7:0] rx_data;
	logic       tx_start;
	logic [7:0] tx_data;
	logic       tx_busy;

	frame_if frame ();

	uart_phy i_phy (.clk_sys, .reset, .rxd(com_232_rx), .tx_start, .tx_data,
		.txd(com_232_tx), .rx_valid, .rx_data, .tx_busy);

	frame_parser i_parser (.clk_sys, .reset, .rx_valid, .rx_data, .frame(frame.parser));

	cmd_decoder i_decoder (.clk_sys, .reset, .frame(frame.decoder), .soft_reset_cmd,
		.spi_flash_switch, .energy_fetch, .bridge_mode_set);

	status_reporter i_reporter (.clk_sys, .reset, .a7_led, .fpga_version_optic,
		.fpga_time_optic, .sfp_abs, .sfp_los, .rx_comm_err, .rx_verify_err,
		.serdes_state, .tx_busy, .fpga_led, .tx_start, .tx_data);

endmodule

// File: design/status_reporter.sv
// board status reporter
`timescale 1ns/1ps

module status_reporter
	import uart_app_pkg::*;
(
	input  logic              clk_sys,
	input  logic              reset,
	input  logic              a7_led,
	input  logic [31:0]       fpga_version_optic,
	input  logic [31:0]       fpga_time_optic,
	input  logic [ch_num-1:0] sfp_abs,
	input  logic [ch_num-1:0] sfp_los,
	input  logic [ch_num-1:0] rx_comm_err,
	input  logic [ch_num-1:0] rx_verify_err,
	input  logic [10:0]       serdes_state,
	input  logic              tx_busy,
	output logic              fpga_led,
	output logic              tx_start,
	output logic [7:0]        tx_data
);

	logic [2:0] led_sync;
	logic       led_prev;
	logic       led_fall;
	logic       busy_d;
	logic       active;	// report in progress
	logic [4:0] byte_idx;	// next byte to send
	logic [4:0] sel_idx;
	logic       send_now;
	logic [7:0] report_byte;

	// ------------------------------------------------------------
	// led sync and edge detect
	always_ff @(posedge clk_sys)
	begin
		if (reset)
		begin
			led_sync <= '0;
			led_prev <= 1'b0;
			busy_d <= 1'b0;
		end
		else
		begin
			led_sync <= {led_sync[1:0], a7_led};
			led_prev <= led_sync[2];
			busy_d <= tx_busy;
		end
	end

	assign fpga_led = led_sync[2];
	assign led_fall = led_prev && !led_sync[2];

	// a new edge restarts at the header, held until the line is free
	assign send_now = led_fall ? (!tx_busy && !tx_start) : (active && busy_d && !tx_busy);
	assign sel_idx = led_fall ? 5'd0 : byte_idx;

	// ------------------------------------------------------------
	// byte sequencer
	always_ff @(posedge clk_sys)
	begin
		if (reset)
		begin
			active <= 1'b0;
			byte_idx <= '0;
			tx_start <= 1'b0;
		end
		else
		begin
			tx_start <= send_now;
			if (led_fall)
			begin
				active <= 1'b1;
				byte_idx <= send_now ? 5'd1 : 5'd0;
			end
			else if (send_now)
			begin
				byte_idx <= byte_idx + 5'd1;
				if (byte_idx == 5'(report_len + 8'd4))
					active <= 1'b0;	// tail byte going out
			end
		end
	end

	always_comb
	begin
		case (sel_idx)
			5'd0:  report_byte = frame_head;
			5'd1:  report_byte = report_cmd;
			5'd2:  report_byte = 8'h00;
			5'd3:  report_byte = report_len;
			5'd4:  report_byte = fpga_version_optic[31:24];
			5'd5:  report_byte = fpga_version_optic[23:16];
			5'd6:  report_byte = fpga_version_optic[15:8];
			5'd7:  report_byte = fpga_version_optic[7:0];
			5'd8:  report_byte = fpga_time_optic[31:24];
			5'd9:  report_byte = fpga_time_optic[23:16];
			5'd10: report_byte = fpga_time_optic[15:8];
			5'd11: report_byte = fpga_time_optic[7:0];
			5'd12: report_byte = 8'(sfp_abs >> 8);	// upper channels, zero padded
			5'd13: report_byte = sfp_abs[7:0];
			5'd14: report_byte = 8'(sfp_los >> 8);
			5'd15: report_byte = sfp_los[7:0];
			5'd16: report_byte = 8'(rx_comm_err >> 8);
			5'd17: report_byte = rx_comm_err[7:0];
			5'd18: report_byte = 8'(rx_verify_err >> 8);
			5'd19: report_byte = rx_verify_err[7:0];
			5'd20: report_byte = 8'(serdes_state >> 8);
			5'd21: report_byte = serdes_state[7:0];
			default: report_byte = frame_tail;
		endcase
	end

	always_ff @(posedge clk_sys)
	begin
		if (send_now)
			tx_data <= report_byte;
	end

endmodule

// File: design/cmd_decoder.sv
// host command decoder
`timescale 1ns/1ps

module cmd_decoder
	import uart_app_pkg::*;
(
	input  logic              clk_sys,
	input  logic              reset,
	frame_if.decoder          frame,
	output logic              soft_reset_cmd,
	output logic              spi_flash_switch,	// 1 routes spi to flash download
	output logic [ch_num-1:0] energy_fetch,
	output logic [ch_num-1:0] bridge_mode_set	// 0 half bridge, 1 full bridge
);

	logic fault_reset_cmd;	// only clears the energy mask
	logic reset_code;

	// byte 1 holds the upper channel bits, byte 2 the lower eight
	function automatic logic [ch_num-1:0] mask_write(input logic [ch_num-1:0] mask,
		input logic [idx_w-1:0] idx, input logic [7:0] byte_in);
		logic [ch_num-1:0] m;
		m = mask;
		if (idx == idx_w'(1))
			m[ch_num-1:8] = byte_in[ch_num-9:0];
		else if (idx == idx_w'(2))
			m[7:0] = byte_in;
		return m;
	endfunction

	assign reset_code = frame.payload_valid && frame.cmd == cmd_reset
		&& frame.index == idx_w'(1);

	// ------------------------------------------------------------
	// reset pulses and flash switch
	always_ff @(posedge clk_sys)
	begin
		if (reset)
		begin
			soft_reset_cmd <= 1'b0;
			fault_reset_cmd <= 1'b0;
		end
		else
		begin
			soft_reset_cmd <= reset_code && frame.data == reset_soft;
			fault_reset_cmd <= reset_code && frame.data == reset_fault;
		end
	end

	always_ff @(posedge clk_sys)
	begin
		if (reset)
			spi_flash_switch <= 1'b0;
		else if (frame.frame_end && frame.cmd == cmd_flash)
			spi_flash_switch <= 1'b1;	// takes effect on a clean tail only
		else if (soft_reset_cmd)
			spi_flash_switch <= 1'b0;
	end

	// ------------------------------------------------------------
	// channel masks
	always_ff @(posedge clk_sys)
	begin
		if (reset || soft_reset_cmd)
			energy_fetch <= energy_default;
		else if (fault_reset_cmd)
			energy_fetch <= '0;
		else if (frame.payload_valid && frame.cmd == cmd_energy)
			energy_fetch <= mask_write(energy_fetch, frame.index, frame.data);
	end

	always_ff @(posedge clk_sys)
	begin
		if (reset)
			bridge_mode_set <= '0;
		else if (frame.payload_valid && frame.cmd == cmd_bridge)
			bridge_mode_set <= mask_write(bridge_mode_set, frame.index, frame.data);
	end

	a_one_reset_kind: assert property (@(posedge clk_sys) disable iff (reset)
		!(soft_reset_cmd && fault_reset_cmd));

endmodule

// File: design/frame_parser.sv
// host frame parser
`timescale 1ns/1ps

module frame_parser
	import uart_app_pkg::*;
(
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       rx_valid,
	input  logic [7:0] rx_data,
	frame_if.parser    frame
);

	logic [2:0]       state;
	logic [idx_w-1:0] len_q;	// payload length of current frame

	always_ff @(posedge clk_sys)
	begin
		if (reset)
		begin
			state <= ps_idle;
			len_q <= '0;
			frame.index <= '0;
			frame.payload_valid <= 1'b0;
			frame.frame_end <= 1'b0;
		end
		else
		begin
			frame.payload_valid <= 1'b0;
			frame.frame_end <= 1'b0;
			if (rx_valid)
			begin
				case (state)
					ps_idle: if (rx_data == frame_head)
						state <= ps_cmd;	// anything else is noise
					ps_cmd:  state <= ps_rsv1;
					ps_rsv1: state <= ps_len;
					ps_len:
					begin
						len_q <= rx_data[idx_w-1:0];
						state <= ps_rsv2;
					end
					ps_rsv2:
					begin
						frame.index <= '0;
						state <= (len_q == '0) ? ps_tail : ps_payload;
					end
					ps_payload:
					begin
						frame.payload_valid <= 1'b1;
						frame.index <= frame.index + 1'b1;
						if (frame.index + 1'b1 == len_q)
							state <= ps_tail;
					end
					ps_tail:
					begin
						frame.frame_end <= (rx_data == frame_tail);	// bad tail drops frame
						state <= ps_idle;
					end
					default: state <= ps_idle;
				endcase
			end
		end
	end

	// payload registers
	always_ff @(posedge clk_sys)
	begin
		if (rx_valid)
			frame.data <= rx_data;
		if (rx_valid && state == ps_cmd)
			frame.cmd <= rx_data;
	end

	a_index_in_range: assert property (@(posedge clk_sys) disable iff (reset)
		frame.payload_valid |-> (frame.index != '0 && frame.index <= len_q));

endmodule

// File: design/uart_phy.sv
// serial byte transceiver
`timescale 1ns/1ps

module uart_phy
	import uart_app_pkg::*;
(
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       rxd,
	input  logic       tx_start,
	input  logic [7:0] tx_data,
	output logic       txd,
	output logic       rx_valid,
	output logic [7:0] rx_data,
	output logic       tx_busy
);

	logic [1:0] rx_sync;
	logic       rx_active;
	logic [3:0] rx_bit;	// 0 start, 1-8 data, 9 stop
	logic [$clog2(clks_per_bit)-1:0] rx_cnt;
	logic [7:0] rx_shift;
	logic       rx_mid;

	logic [9:0] tx_shift;	// stop, data, start
	logic [3:0] tx_bit;
	logic [$clog2(clks_per_bit)-1:0] tx_cnt;

	// ------------------------------------------------------------
	// receiver
	always_ff @(posedge clk_sys)
	begin
		if (reset)
			rx_sync <= 2'b11;	// line idles high
		else
			rx_sync <= {rx_sync[0], rxd};
	end

	// start bit checked half a bit in, the rest at full bit spacing
	assign rx_mid = (rx_bit == 4'd0) ? (rx_cnt == clks_per_bit / 2 - 1)
		: (rx_cnt == clks_per_bit - 1);

	always_ff @(posedge clk_sys)
	begin
		if (reset)
		begin
			rx_active <= 1'b0;
			rx_bit <= '0;
			rx_cnt <= '0;
			rx_valid <= 1'b0;
		end
		else
		begin
			rx_valid <= 1'b0;
			if (!rx_active)
			begin
				rx_active <= !rx_sync[1];	// falling edge opens a byte
				rx_bit <= '0;
				rx_cnt <= '0;
			end
			else if (rx_mid)
			begin
				rx_cnt <= '0;
				if (rx_bit == 4'd0 && rx_sync[1])
					rx_active <= 1'b0;	// glitch, not a start bit
				else if (rx_bit == 4'd9)
				begin
					rx_active <= 1'b0;
					rx_valid <= rx_sync[1];	// drop on framing error
				end
				else
					rx_bit <= rx_bit + 4'd1;
			end
			else
				rx_cnt <= rx_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk_sys)
	begin
		if (rx_active && rx_mid && rx_bit != 4'd0 && rx_bit != 4'd9)
			rx_shift <= {rx_sync[1], rx_shift[7:1]};	// lsb first
		if (rx_active && rx_mid && rx_bit == 4'd9)
			rx_data <= rx_shift;
	end

	// ------------------------------------------------------------
	// transmitter
	always_ff @(posedge clk_sys)
	begin
		if (reset)
		begin
			tx_busy <= 1'b0;
			tx_bit <= '0;
			tx_cnt <= '0;
		end
		else if (!tx_busy)
		begin
			tx_busy <= tx_start;
			tx_bit <= '0;
			tx_cnt <= '0;
		end
		else if (tx_cnt == clks_per_bit - 1)
		begin
			tx_cnt <= '0;
			tx_bit <= tx_bit + 4'd1;
			if (tx_bit == 4'd9)
				tx_busy <= 1'b0;	// stop bit done
		end
		else
			tx_cnt <= tx_cnt + 1'b1;
	end

	always_ff @(posedge clk_sys)
	begin
		if (!tx_busy && tx_start)
			tx_shift <= {1'b1, tx_data, 1'b0};
		else if (tx_busy && tx_cnt == clks_per_bit - 1)
			tx_shift <= {1'b1, tx_shift[9:1]};
	end

	assign txd = tx_busy ? tx_shift[0] : 1'b1;

	// the reporter must wait for the previous byte
	a_no_start_when_busy: assert property (@(posedge clk_sys) disable iff (reset)
		tx_start |-> !tx_busy);

endmodule

// File: design/frame_if.sv
// parsed host frame events
`timescale 1ns/1ps

interface frame_if
	import uart_app_pkg::*;
();

	logic             payload_valid;	// one strobe per payload byte
	logic [7:0]       data;
	logic [7:0]       cmd;	// held for the whole frame
	logic [idx_w-1:0] index;	// 1-based, valid with payload_valid
	logic             frame_end;	// tail byte matched

	modport parser (output payload_valid, data, cmd, index, frame_end);

	modport decoder (input payload_valid, data, cmd, index, frame_end);

endinterface

// File: design/uart_app_pkg.sv
// uart endpoint shared constants
package uart_app_pkg;

	// ------------------------------------------------------------
	// serial timing
	localparam int clks_per_bit = 8;	// 8N1, 12.5 Mbaud from 100 MHz

	// ------------------------------------------------------------
	// frame bytes and command codes
	localparam logic [7:0] frame_head = 8'hBE;
	localparam logic [7:0] frame_tail = 8'hED;
	localparam logic [7:0] report_cmd = 8'h03;
	localparam logic [7:0] report_len = 8'd18;	// status payload bytes

	localparam logic [7:0] cmd_flash  = 8'h00;
	localparam logic [7:0] cmd_reset  = 8'h04;
	localparam logic [7:0] cmd_energy = 8'h25;
	localparam logic [7:0] cmd_bridge = 8'h30;

	localparam logic [7:0] reset_soft  = 8'h00;	// first payload byte of cmd_reset
	localparam logic [7:0] reset_fault = 8'h01;

	// ------------------------------------------------------------
	// widths
	localparam int ch_num = 14;	// optical channels 0-13
	localparam int idx_w  = 7;	// payload index, up to 127 bytes

	localparam logic [ch_num-1:0] energy_default = '1;

	// host frame parser states
	localparam logic [2:0] ps_idle    = 3'd0;
	localparam logic [2:0] ps_cmd     = 3'd1;
	localparam logic [2:0] ps_rsv1    = 3'd2;
	localparam logic [2:0] ps_len     = 3'd3;
	localparam logic [2:0] ps_rsv2    = 3'd4;
	localparam logic [2:0] ps_payload = 3'd5;
	localparam logic [2:0] ps_tail    = 3'd6;

endpackage
